// ==== design/dbg_pkg.sv ====
package dbg_pkg;

  //////////////////////////////////////////////////
  // widths

  // data and debug address width
  localparam int XLEN = 64;
  localparam int PLEN = 64;

  // architectural register file
  localparam int NUM_GPR   = 32;
  localparam int GPR_IDX_W = $clog2(NUM_GPR);

  // pc after reset
  localparam logic [XLEN-1:0] RESET_PC = 64'h200;

  //////////////////////////////////////////////////
  // hardware breakpoints

  localparam int NUM_BP   = 4;
  localparam int BP_SEL_W = $clog2(NUM_BP);

  //////////////////////////////////////////////////
  // debug address map, word addresses

  localparam logic [PLEN-1:0] ADR_CTRL     = 64'h0000;
  localparam logic [PLEN-1:0] ADR_HIT      = 64'h0001;
  localparam logic [PLEN-1:0] ADR_PC       = 64'h0002;
  // read-only
  localparam logic [PLEN-1:0] ADR_INSTRET  = 64'h0003;
  // bp address regs, one word each
  localparam logic [PLEN-1:0] ADR_BP_BASE  = 64'h0010;
  // x0 .. x31
  localparam logic [PLEN-1:0] ADR_GPR_BASE = 64'h1000;

  // control register fields
  localparam int CTRL_STEP   = 0;
  localparam int CTRL_BP_LSB = 4;

  //////////////////////////////////////////////////
  // halt reason bits

  localparam int HIT_STEP = 0;
  localparam int HIT_BP   = 1;
  localparam int HIT_W    = 2;

endpackage

// ==== design/hart_core.sv ====
`timescale 1ns/100ps

module hart_core import dbg_pkg::*; (
  input  logic                 clk,
  input  logic                 rstn,

  // retire strobe from the breakpoint unit
  input  logic                 retire_en_i,

  // debugger pc write
  input  logic                 pc_we_i,
  input  logic [XLEN-1:0]      pc_wdat_i,

  // debugger gpr access
  input  logic                 gpr_we_i,
  input  logic [GPR_IDX_W-1:0] gpr_idx_i,
  input  logic [XLEN-1:0]      gpr_wdat_i,
  output logic [XLEN-1:0]      gpr_rdat_o,

  // architectural state seen by the debugger
  output logic [XLEN-1:0]      pc_o,
  output logic [XLEN-1:0]      instret_o
);

  //////////////////////////////////////////////////
  // state

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] instret;

  // integer register file
  logic [XLEN-1:0] gpr [NUM_GPR];

  //////////////////////////////////////////////////
  // program counter

  // no fetch or execute here, the hart just walks through
  // sequential 4-byte instructions
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      pc <= RESET_PC;
    end else if (pc_we_i) begin
      // redirect beats the advance
      pc <= pc_wdat_i;
    end else if (retire_en_i) begin
      pc <= pc + XLEN'(4);
    end
  end

  //////////////////////////////////////////////////
  // retire counter

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      instret <= '0;
    end else if (retire_en_i) begin
      instret <= instret + XLEN'(1);
    end
  end

  //////////////////////////////////////////////////
  // gpr file

  // x0 is hardwired, never written
  always_ff @(posedge clk) begin
    if (gpr_we_i && (gpr_idx_i != '0)) begin
      gpr[gpr_idx_i] <= gpr_wdat_i;
    end
  end

  // async read, x0 reads zero
  assign gpr_rdat_o = (gpr_idx_i == '0) ? '0 : gpr[gpr_idx_i];

  // outputs
  assign pc_o      = pc;
  assign instret_o = instret;

endmodule

// ==== design/dbg_bp_unit.sv ====
`timescale 1ns/100ps

module dbg_bp_unit import dbg_pkg::*; (
  input  logic                clk,
  input  logic                rstn,

  // host stall level
  input  logic                stall_i,

  // current pc of the hart
  input  logic [XLEN-1:0]     pc_i,

  // control bits
  input  logic                step_en_i,
  input  logic [NUM_BP-1:0]   bp_ena_i,

  // breakpoint address access
  input  logic                bp_we_i,
  input  logic [BP_SEL_W-1:0] bp_sel_i,
  input  logic [XLEN-1:0]     bp_wdat_i,
  output logic [XLEN-1:0]     bp_rdat_o,

  // halt reason, write one to clear
  input  logic [HIT_W-1:0]    hit_clr_i,
  output logic [HIT_W-1:0]    hit_o,
  output logic                halt_o,

  // hart may retire this cycle
  output logic                retire_en_o
);

  //////////////////////////////////////////////////
  // signals

  logic [XLEN-1:0]   bp_adr [NUM_BP];
  logic [NUM_BP-1:0] bp_match;
  logic              bp_block;
  logic              skip;
  logic [HIT_W-1:0]  hit;
  logic [HIT_W-1:0]  hit_set;

  //////////////////////////////////////////////////
  // breakpoint address registers

  always_ff @(posedge clk) begin
    if (bp_we_i) begin
      bp_adr[bp_sel_i] <= bp_wdat_i;
    end
  end

  assign bp_rdat_o = bp_adr[bp_sel_i];

  //////////////////////////////////////////////////
  // match and retire decision

  // compare pc against every enabled entry
  always_comb begin
    for (int i = 0; i < NUM_BP; i++) begin
      bp_match[i] = bp_ena_i[i] && (pc_i == bp_adr[i]);
    end
  end

  // skip lets the hart step off the bp it just halted on
  assign bp_block = (|bp_match) && !stall_i && !skip;

  assign halt_o      = |hit;
  assign retire_en_o = !stall_i && !halt_o && !bp_block;

  // armed by any stall, dropped by the next retire
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      skip <= 1'b0;
    end else if (stall_i) begin
      skip <= 1'b1;
    end else if (retire_en_o) begin
      skip <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // sticky hit bits

  // step sets on the same edge as the retire it covers
  always_comb begin
    hit_set           = '0;
    hit_set[HIT_BP]   = bp_block;
    hit_set[HIT_STEP] = retire_en_o && step_en_i;
  end

  // a new hit wins over a clear in the same cycle
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      hit <= '0;
    end else begin
      hit <= (hit & ~hit_clr_i) | hit_set;
    end
  end

  assign hit_o = hit;

endmodule

// ==== design/dbg_regs.sv ====
`timescale 1ns/100ps

module dbg_regs import dbg_pkg::*; (
  input  logic                 clk,
  input  logic                 rstn,

  // debug port from the host
  input  logic                 dbg_stall_i,
  input  logic                 dbg_stb_i,
  input  logic                 dbg_we_i,
  input  logic [PLEN-1:0]      dbg_adr_i,
  input  logic [XLEN-1:0]      dbg_dat_i,
  output logic [XLEN-1:0]      dbg_dat_o,
  output logic                 dbg_ack_o,

  // control register fields
  output logic                 step_en_o,
  output logic [NUM_BP-1:0]    bp_ena_o,

  // breakpoint unit
  output logic                 bp_we_o,
  output logic [BP_SEL_W-1:0]  bp_sel_o,
  output logic [XLEN-1:0]      bp_wdat_o,
  input  logic [XLEN-1:0]      bp_rdat_i,
  output logic [HIT_W-1:0]     hit_clr_o,
  input  logic [HIT_W-1:0]     hit_i,

  // hart
  output logic                 pc_we_o,
  output logic [XLEN-1:0]      pc_wdat_o,
  input  logic [XLEN-1:0]      pc_i,
  input  logic [XLEN-1:0]      instret_i,
  output logic                 gpr_we_o,
  output logic [GPR_IDX_W-1:0] gpr_idx_o,
  output logic [XLEN-1:0]      gpr_wdat_o,
  input  logic [XLEN-1:0]      gpr_rdat_i
);

  //////////////////////////////////////////////////
  // signals

  logic              busy;
  logic              start;
  logic              wr;
  logic              sel_ctrl;
  logic              sel_hit;
  logic              sel_pc;
  logic              sel_instret;
  logic              sel_bp;
  logic              sel_gpr;
  logic              ctrl_step;
  logic [NUM_BP-1:0] ctrl_bp_ena;
  logic [XLEN-1:0]   ctrl_rd;
  logic [XLEN-1:0]   rd_data;

  //////////////////////////////////////////////////
  // strobe / ack handshake

  // first sampled stb starts the access, busy blocks a repeat
  // until stb has been seen low again
  assign start = dbg_stb_i && !busy;
  assign wr    = start && dbg_we_i;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      busy      <= 1'b0;
      dbg_ack_o <= 1'b0;
    end else begin
      busy      <= dbg_stb_i;
      // single cycle ack
      dbg_ack_o <= start;
    end
  end

  //////////////////////////////////////////////////
  // address decode

  assign sel_ctrl    = (dbg_adr_i == ADR_CTRL);
  assign sel_hit     = (dbg_adr_i == ADR_HIT);
  assign sel_pc      = (dbg_adr_i == ADR_PC);
  assign sel_instret = (dbg_adr_i == ADR_INSTRET);
  assign sel_bp      = (dbg_adr_i >= ADR_BP_BASE) && (dbg_adr_i < ADR_BP_BASE + NUM_BP);
  assign sel_gpr     = (dbg_adr_i >= ADR_GPR_BASE) && (dbg_adr_i < ADR_GPR_BASE + NUM_GPR);

  //////////////////////////////////////////////////
  // control register

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      ctrl_step   <= 1'b0;
      ctrl_bp_ena <= '0;
    end else if (wr && sel_ctrl) begin
      ctrl_step   <= dbg_dat_i[CTRL_STEP];
      ctrl_bp_ena <= dbg_dat_i[CTRL_BP_LSB +: NUM_BP];
    end
  end

  assign step_en_o = ctrl_step;
  assign bp_ena_o  = ctrl_bp_ena;

  // unused ctrl bits read zero
  always_comb begin
    ctrl_rd                         = '0;
    ctrl_rd[CTRL_STEP]              = ctrl_step;
    ctrl_rd[CTRL_BP_LSB +: NUM_BP]  = ctrl_bp_ena;
  end

  //////////////////////////////////////////////////
  // write strobes

  // bp and hit writes work while the hart runs
  assign bp_we_o   = wr && sel_bp;
  assign bp_sel_o  = dbg_adr_i[BP_SEL_W-1:0];
  assign bp_wdat_o = dbg_dat_i;
  assign hit_clr_o = (wr && sel_hit) ? dbg_dat_i[HIT_W-1:0] : '0;

  // pc and gpr only change under stall, else acked and dropped
  assign pc_we_o    = wr && sel_pc && dbg_stall_i;
  assign pc_wdat_o  = dbg_dat_i;
  assign gpr_we_o   = wr && sel_gpr && dbg_stall_i;
  assign gpr_idx_o  = dbg_adr_i[GPR_IDX_W-1:0];
  assign gpr_wdat_o = dbg_dat_i;

  //////////////////////////////////////////////////
  // read mux

  // unmapped reads zero
  always_comb begin
    rd_data = '0;
    if (sel_ctrl)    rd_data = ctrl_rd;
    if (sel_hit)     rd_data = XLEN'(hit_i);
    if (sel_pc)      rd_data = pc_i;
    if (sel_instret) rd_data = instret_i;
    if (sel_bp)      rd_data = bp_rdat_i;
    if (sel_gpr)     rd_data = gpr_rdat_i;
  end

  // captured on the start edge, valid during ack
  always_ff @(posedge clk) begin
    if (start) begin
      dbg_dat_o <= rd_data;
    end
  end

endmodule

// ==== design/dbg_top.sv ====
`timescale 1ns/100ps

module dbg_top import dbg_pkg::*; (
  input  logic            clk,
  input  logic            rstn,

  // debug port
  input  logic            dbg_stall_i,
  input  logic            dbg_stb_i,
  input  logic            dbg_we_i,
  input  logic [PLEN-1:0] dbg_adr_i,
  input  logic [XLEN-1:0] dbg_dat_i,
  output logic [XLEN-1:0] dbg_dat_o,
  output logic            dbg_ack_o,
  output logic            dbg_bp_o
);

  //////////////////////////////////////////////////
  // internal nets

  // regs to bp unit
  logic                 step_en;
  logic [NUM_BP-1:0]    bp_ena;
  logic                 bp_we;
  logic [BP_SEL_W-1:0]  bp_sel;
  logic [XLEN-1:0]      bp_wdat;
  logic [XLEN-1:0]      bp_rdat;
  logic [HIT_W-1:0]     hit_clr;
  logic [HIT_W-1:0]     hit;

  // regs to hart
  logic                 pc_we;
  logic [XLEN-1:0]      pc_wdat;
  logic                 gpr_we;
  logic [GPR_IDX_W-1:0] gpr_idx;
  logic [XLEN-1:0]      gpr_wdat;
  logic [XLEN-1:0]      gpr_rdat;

  // hart state and retire
  logic [XLEN-1:0]      pc;
  logic [XLEN-1:0]      instret;
  logic                 retire_en;

  //////////////////////////////////////////////////
  // blocks

  hart_core hart_core_i (
    .clk         (clk),
    .rstn        (rstn),
    .retire_en_i (retire_en),
    .pc_we_i     (pc_we),
    .pc_wdat_i   (pc_wdat),
    .gpr_we_i    (gpr_we),
    .gpr_idx_i   (gpr_idx),
    .gpr_wdat_i  (gpr_wdat),
    .gpr_rdat_o  (gpr_rdat),
    .pc_o        (pc),
    .instret_o   (instret)
  );

  // bp level to the host is the halt flag
  dbg_bp_unit dbg_bp_unit_i (
    .clk         (clk),
    .rstn        (rstn),
    .stall_i     (dbg_stall_i),
    .pc_i        (pc),
    .step_en_i   (step_en),
    .bp_ena_i    (bp_ena),
    .bp_we_i     (bp_we),
    .bp_sel_i    (bp_sel),
    .bp_wdat_i   (bp_wdat),
    .bp_rdat_o   (bp_rdat),
    .hit_clr_i   (hit_clr),
    .hit_o       (hit),
    .halt_o      (dbg_bp_o),
    .retire_en_o (retire_en)
  );

  dbg_regs dbg_regs_i (
    .clk         (clk),
    .rstn        (rstn),
    .dbg_stall_i (dbg_stall_i),
    .dbg_stb_i   (dbg_stb_i),
    .dbg_we_i    (dbg_we_i),
    .dbg_adr_i   (dbg_adr_i),
    .dbg_dat_i   (dbg_dat_i),
    .dbg_dat_o   (dbg_dat_o),
    .dbg_ack_o   (dbg_ack_o),
    .step_en_o   (step_en),
    .bp_ena_o    (bp_ena),
    .bp_we_o     (bp_we),
    .bp_sel_o    (bp_sel),
    .bp_wdat_o   (bp_wdat),
    .bp_rdat_i   (bp_rdat),
    .hit_clr_o   (hit_clr),
    .hit_i       (hit),
    .pc_we_o     (pc_we),
    .pc_wdat_o   (pc_wdat),
    .pc_i        (pc),
    .instret_i   (instret),
    .gpr_we_o    (gpr_we),
    .gpr_idx_o   (gpr_idx),
    .gpr_wdat_o  (gpr_wdat),
    .gpr_rdat_i  (gpr_rdat)
  );

endmodule

// ==== tb/dbg_bfm.sv ====
`timescale 1ns/100ps

module dbg_bfm import dbg_pkg::*; (
  input  logic            clk,
  input  logic            rstn,

  // stall level into the hart
  output logic            stall_o,

  // strobe/ack bus, host side
  output logic            stb_o,
  output logic            we_o,
  output logic [PLEN-1:0] adr_o,
  output logic [XLEN-1:0] dat_o,
  input  logic [XLEN-1:0] dat_i,
  input  logic            ack_i,

  // halt level from the DUT
  input  logic            bp_i
);

  // cycles to wait for ack before giving up on an access
  localparam int ACK_TIMEOUT = 16;

  logic bp_q;
  int   ack_errors = 0;

  // idle bus, hart running
  initial begin
    stall_o = 1'b0;
    stb_o   = 1'b0;
    we_o    = 1'b0;
    adr_o   = '0;
    dat_o   = '0;
  end

  //////////////////////////////////////////////////
  // automatic stall on a rising halt level

  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bp_q <= 1'b0;
    end else begin
      bp_q <= bp_i;
      if (bp_i && !bp_q) begin
        stall_o <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // host tasks

  task automatic stall();
    @(posedge clk);
    stall_o <= 1'b1;
  endtask

  task automatic unstall();
    @(posedge clk);
    stall_o <= 1'b0;
  endtask

  // one access, stb dropped on the edge where ack is seen
  task automatic access(input logic wr, input logic [PLEN-1:0] adr,
                        input logic [XLEN-1:0] wdat, output logic [XLEN-1:0] rdat);
    int n;
    n    = 0;
    rdat = '0;
    @(posedge clk);
    stb_o <= 1'b1;
    we_o  <= wr;
    adr_o <= adr;
    dat_o <= wdat;
    do begin
      @(posedge clk);
      n++;
    end while (!ack_i && (n < ACK_TIMEOUT));
    if (ack_i) begin
      rdat = dat_i;
    end else begin
      ack_errors++;
      $display("ERROR at %0t: no ack from DUT for access to address 0x%0h", $time, adr);
    end
    stb_o <= 1'b0;
    we_o  <= 1'b0;
  endtask

  task automatic write(input logic [PLEN-1:0] adr, input logic [XLEN-1:0] wdat);
    logic [XLEN-1:0] unused;
    access(1'b1, adr, wdat, unused);
  endtask

  task automatic read(input logic [PLEN-1:0] adr, output logic [XLEN-1:0] rdat);
    access(1'b0, adr, '0, rdat);
  endtask

  // wait until a halt has stalled the hart, ok low on timeout
  task automatic wait_halt(input int max_cycles, output bit ok);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!(stall_o && bp_i) && (n < max_cycles));
    ok = stall_o && bp_i;
  endtask

endmodule

// ==== tb/tb_dbg_top.sv ====
`timescale 1ns/100ps

module tb_dbg_top import dbg_pkg::*; ();

  localparam int CLK_PERIOD   = 20;
  // rough length of all tests in cycles
  // watchdog allows five times that
  localparam int EST_CYCLES   = 400;
  localparam int WATCHDOG_NS  = 5 * EST_CYCLES * CLK_PERIOD;
  localparam int HALT_TIMEOUT = 64;

  logic            clk;
  logic            rstn;
  logic            dbg_stall;
  logic            dbg_stb;
  logic            dbg_we;
  logic [PLEN-1:0] dbg_adr;
  logic [XLEN-1:0] dbg_wdat;
  logic [XLEN-1:0] dbg_rdat;
  logic            dbg_ack;
  logic            dbg_bp;

  int seed       = 50892;
  int errors     = 0;
  int tests      = 0;
  int bad_tests  = 0;

  //////////////////////////////////////////////////
  // clock, DUT and host

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  dbg_top dbg_top_i (
    .clk         (clk),
    .rstn        (rstn),
    .dbg_stall_i (dbg_stall),
    .dbg_stb_i   (dbg_stb),
    .dbg_we_i    (dbg_we),
    .dbg_adr_i   (dbg_adr),
    .dbg_dat_i   (dbg_wdat),
    .dbg_dat_o   (dbg_rdat),
    .dbg_ack_o   (dbg_ack),
    .dbg_bp_o    (dbg_bp)
  );

  dbg_bfm bfm_i (
    .clk     (clk),
    .rstn    (rstn),
    .stall_o (dbg_stall),
    .stb_o   (dbg_stb),
    .we_o    (dbg_we),
    .adr_o   (dbg_adr),
    .dat_o   (dbg_wdat),
    .dat_i   (dbg_rdat),
    .ack_i   (dbg_ack),
    .bp_i    (dbg_bp)
  );

  //////////////////////////////////////////////////
  // helpers

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  function automatic logic [XLEN-1:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  task automatic report_mismatch(input string msg, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
    errors++;
    $display("CHECK FAILED at %0t: %s, got 0x%0h expected 0x%0h", $time, msg, got, exp);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic close_test(input string name, input int err0);
    tests++;
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      bad_tests++;
      $display("test %s: %0d error(s)", name, errors - err0);
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests

  // pc tracks retire count on a free running hart
  task automatic reset_and_run();
    logic [XLEN-1:0] val;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] ret;
    logic [XLEN-1:0] ret_first;
    int              err0;
    err0 = errors;
    if (dbg_ack !== 1'b0 || dbg_bp !== 1'b0)
      report_error("ack or bp not low after reset");
    for (int pass = 0; pass < 2; pass++) begin
      repeat (rand_range(10, 40)) @(posedge clk);
      bfm_i.stall();
      bfm_i.read(ADR_CTRL, val);
      if (val !== '0)
        report_mismatch("CTRL after reset", val, '0);
      bfm_i.read(ADR_HIT, val);
      if (val !== '0)
        report_mismatch("HIT while free running", val, '0);
      bfm_i.read(ADR_PC, pc);
      bfm_i.read(ADR_INSTRET, ret);
      if (pc !== RESET_PC + 4 * ret)
        report_mismatch("PC against INSTRET", pc, RESET_PC + 4 * ret);
      if (pass == 0) begin
        ret_first = ret;
        bfm_i.unstall();
      end else if (ret <= ret_first) begin
        report_error("INSTRET did not grow over the second run");
      end
    end
    close_test("reset_and_run", err0);
  endtask

  // gpr file through the port with stall gated writes
  task automatic gpr_access();
    logic [XLEN-1:0] data [8];
    int              idx [8];
    logic [XLEN-1:0] val;
    int              err0;
    err0 = errors;
    // one register from each group of four in x1 to x31
    for (int k = 0; k < 8; k++) begin
      idx[k]  = 4 * k + rand_range(1, 3);
      data[k] = rand_word();
      bfm_i.write(ADR_GPR_BASE + idx[k], data[k]);
    end
    for (int k = 0; k < 8; k++) begin
      bfm_i.read(ADR_GPR_BASE + idx[k], val);
      if (val !== data[k])
        report_mismatch($sformatf("GPR x%0d readback", idx[k]), val, data[k]);
    end
    bfm_i.write(ADR_GPR_BASE, rand_word());
    bfm_i.read(ADR_GPR_BASE, val);
    if (val !== '0)
      report_mismatch("x0 after write", val, '0);
    // write while running is dropped
    bfm_i.unstall();
    bfm_i.write(ADR_GPR_BASE + idx[0], ~data[0]);
    bfm_i.stall();
    bfm_i.read(ADR_GPR_BASE + idx[0], val);
    if (val !== data[0])
      report_mismatch("GPR written while running", val, data[0]);
    // unmapped space
    bfm_i.write(64'h0500, rand_word());
    bfm_i.read(64'h0500, val);
    if (val !== '0)
      report_mismatch("unmapped address 0x500", val, '0);
    // past x31 with the low bits on a written register
    bfm_i.read(ADR_GPR_BASE + 32 + idx[1], val);
    if (val !== '0)
      report_mismatch("address past x31", val, '0);
    close_test("gpr_access", err0);
  endtask

  // halt on bp0 and then resume past it
  task automatic breakpoint_halt();
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] bp_adr;
    logic [XLEN-1:0] val;
    bit              ok;
    int              err0;
    err0 = errors;
    bfm_i.read(ADR_PC, pc);
    bp_adr = pc + 4 * rand_range(5, 20);
    bfm_i.write(ADR_BP_BASE, bp_adr);
    bfm_i.read(ADR_BP_BASE, val);
    if (val !== bp_adr)
      report_mismatch("BP_ADR0 readback", val, bp_adr);
    // bit 4 enables bp0
    bfm_i.write(ADR_CTRL, 64'h10);
    bfm_i.write(ADR_HIT, 64'h3);
    bfm_i.unstall();
    bfm_i.wait_halt(HALT_TIMEOUT, ok);
    if (!ok)
      report_error("breakpoint did not halt the hart");
    bfm_i.read(ADR_PC, val);
    if (val !== bp_adr)
      report_mismatch("PC at breakpoint", val, bp_adr);
    bfm_i.read(ADR_HIT, val);
    if (val !== XLEN'(1) << HIT_BP)
      report_mismatch("HIT at breakpoint", val, XLEN'(1) << HIT_BP);
    bfm_i.write(ADR_HIT, XLEN'(1) << HIT_BP);
    bfm_i.unstall();
    repeat (rand_range(5, 20)) @(posedge clk);
    bfm_i.stall();
    bfm_i.read(ADR_PC, val);
    if (val <= bp_adr)
      report_error("hart did not resume past the breakpoint");
    close_test("breakpoint_halt", err0);
  endtask

  // exactly one retire with step enabled
  task automatic single_step();
    logic [XLEN-1:0] pc0;
    logic [XLEN-1:0] ret0;
    logic [XLEN-1:0] val;
    bit              ok;
    int              err0;
    err0 = errors;
    // step bit plus bits outside the ctrl fields
    bfm_i.write(ADR_CTRL, 64'hffff_ffff_ffff_ff0f);
    bfm_i.read(ADR_CTRL, val);
    if (val !== 64'h1)
      report_mismatch("CTRL readback", val, 64'h1);
    bfm_i.read(ADR_PC, pc0);
    bfm_i.read(ADR_INSTRET, ret0);
    bfm_i.write(ADR_HIT, 64'h3);
    bfm_i.unstall();
    bfm_i.wait_halt(HALT_TIMEOUT, ok);
    if (!ok)
      report_error("single step did not halt the hart");
    bfm_i.read(ADR_PC, val);
    if (val !== pc0 + 4)
      report_mismatch("PC after step", val, pc0 + 4);
    bfm_i.read(ADR_INSTRET, val);
    if (val !== ret0 + 1)
      report_mismatch("INSTRET after step", val, ret0 + 1);
    bfm_i.read(ADR_HIT, val);
    if (val !== XLEN'(1) << HIT_STEP)
      report_mismatch("HIT after step", val, XLEN'(1) << HIT_STEP);
    close_test("single_step", err0);
  endtask

  // redirect the pc and run from there
  task automatic pc_redirect();
    logic [XLEN-1:0] wval;
    logic [XLEN-1:0] ret0;
    logic [XLEN-1:0] ret1;
    logic [XLEN-1:0] val;
    int              err0;
    err0 = errors;
    // word aligned with the top bits clear so it cannot wrap
    wval = rand_word() & 64'h0000_ffff_ffff_fffc;
    bfm_i.write(ADR_PC, wval);
    bfm_i.read(ADR_PC, val);
    if (val !== wval)
      report_mismatch("PC readback after write", val, wval);
    bfm_i.read(ADR_INSTRET, ret0);
    bfm_i.write(ADR_CTRL, 64'h0);
    bfm_i.write(ADR_HIT, 64'h3);
    bfm_i.unstall();
    repeat (rand_range(10, 40)) @(posedge clk);
    bfm_i.stall();
    bfm_i.read(ADR_PC, val);
    bfm_i.read(ADR_INSTRET, ret1);
    if (val !== wval + 4 * (ret1 - ret0))
      report_mismatch("PC after redirect and run", val, wval + 4 * (ret1 - ret0));
    if (ret1 <= ret0)
      report_error("hart did not run after the redirect");
    close_test("pc_redirect", err0);
  endtask

  //////////////////////////////////////////////////
  // sequence and summary

  initial begin
    rstn = 1'b0;
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    reset_and_run();
    gpr_access();
    breakpoint_halt();
    single_step();
    pc_redirect();
    errors += bfm_i.ack_errors;
    $display("summary: %0d tests, %0d with errors, %0d errors in total",
             tests, bad_tests, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("ERROR at %0t: watchdog expired before the tests finished", $time);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== src.f ====
design/dbg_pkg.sv
design/hart_core.sv
design/dbg_bp_unit.sv
design/dbg_regs.sv
design/dbg_top.sv
tb/dbg_bfm.sv
tb/tb_dbg_top.sv

// ==== Bender.yml ====
package:
  name: dbg_port

sources:
  # package first, then the blocks and the top level
  - design/dbg_pkg.sv
  - design/hart_core.sv
  - design/dbg_bp_unit.sv
  - design/dbg_regs.sv
  - design/dbg_top.sv
  - target: simulation
    files:
      - tb/dbg_bfm.sv
      - tb/tb_dbg_top.sv
